// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := radio_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard src/*.sv tb/*.sv tb/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+tb
src/radio_pkg.sv
src/radio_ctrl_proc.sv
src/radio_settings.sv
src/timekeeper.sv
src/gpio_atr.sv
src/radio_frontend.sv
src/radio_core.sv
tb/radio_tb.sv

// ==== src/gpio_atr.sv ====
/*
 * Front-end GPIO auto transmit/receive
 * Drives the pins from one of four state words picked by the run
 * state, with a direction register and registered input readback
 */

module gpio_atr (
   input  logic                         bus_clk,
   input  logic                         i_reset,
   input  logic                         i_set_stb,
   input  logic [radio_pkg::ADDR_W-1:0] i_set_addr,
   input  logic [radio_pkg::DATA_W-1:0] i_set_data,
   input  logic                         i_run_rx,
   input  logic                         i_run_tx,
   input  logic [radio_pkg::GPIO_W-1:0] i_gpio_in,
   output logic [radio_pkg::GPIO_W-1:0] o_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0] o_gpio_ddr,
   output logic [radio_pkg::GPIO_W-1:0] o_gpio_rb
);

   logic [radio_pkg::GPIO_W-1:0] atr_idle;
   logic [radio_pkg::GPIO_W-1:0] atr_rx;
   logic [radio_pkg::GPIO_W-1:0] atr_tx;
   logic [radio_pkg::GPIO_W-1:0] atr_fdx;

   ////////////////////////////////////////////////////////////////////////////
   // State words and DDR at five addresses from SR_ATR up

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         atr_idle   <= radio_pkg::GPIO_IDLE_DEFAULT;
         atr_rx     <= '0;
         atr_tx     <= '0;
         atr_fdx    <= '0;
         o_gpio_ddr <= radio_pkg::GPIO_DDR_DEFAULT;
      end else if (i_set_stb) begin
         case (i_set_addr)
            radio_pkg::SR_ATR:        atr_idle   <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_ATR + 8'd1: atr_rx     <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_ATR + 8'd2: atr_tx     <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_ATR + 8'd3: atr_fdx    <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_ATR + 8'd4: o_gpio_ddr <= i_set_data[radio_pkg::GPIO_W-1:0];
            default: ;
         endcase
      end
   end

   // Output word follows the run pair
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_gpio_out <= radio_pkg::GPIO_IDLE_DEFAULT;
      end else begin
         case ({i_run_tx, i_run_rx})
            2'b00:   o_gpio_out <= atr_idle;
            2'b01:   o_gpio_out <= atr_rx;
            2'b10:   o_gpio_out <= atr_tx;
            default: o_gpio_out <= atr_fdx;   // Full duplex
         endcase
      end
   end

   // Pin readback
   always_ff @(posedge bus_clk) begin
      o_gpio_rb <= i_gpio_in;
   end

endmodule

// ==== src/radio_core.sv ====
/*
 * Radio core control and housekeeping
 * Control port, settings, timekeeper, front-end GPIO and sample path
 */

module radio_core (
   input  logic                           bus_clk,
   input  logic                           i_reset,
   input  logic                           i_ctrl_stb,
   input  logic [radio_pkg::ADDR_W-1:0]   i_ctrl_addr,
   input  logic [radio_pkg::DATA_W-1:0]   i_ctrl_data,
   output logic                           o_resp_valid,
   output logic [radio_pkg::RB_W-1:0]     o_resp_data,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_tx_sample,
   input  logic                           i_run_tx,
   input  logic                           i_run_rx,
   output logic [radio_pkg::SAMPLE_W-1:0] o_tx,
   output logic [radio_pkg::SAMPLE_W-1:0] o_rx_sample,
   input  logic                           i_pps,
   input  logic [radio_pkg::GPIO_W-1:0]   i_fe_gpio_in,
   output logic [radio_pkg::GPIO_W-1:0]   o_fe_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]   o_fe_gpio_ddr
);

   // Setting bus
   logic                         set_stb;
   logic [radio_pkg::ADDR_W-1:0] set_addr;
   logic [radio_pkg::DATA_W-1:0] set_data;

   logic [radio_pkg::RB_W-1:0]     readback;
   radio_pkg::time_word_u          time_now;
   radio_pkg::time_word_u          time_pps;
   logic                           loopback;
   logic [radio_pkg::SAMPLE_W-1:0] codec_idle;
   logic [radio_pkg::GPIO_W-1:0]   gpio_rb;

   radio_ctrl_proc u_ctrl (
      .bus_clk(bus_clk), .i_reset(i_reset),
      .i_ctrl_stb(i_ctrl_stb), .i_ctrl_addr(i_ctrl_addr), .i_ctrl_data(i_ctrl_data),
      .i_readback(readback),
      .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
      .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data));

   radio_settings u_settings (
      .bus_clk(bus_clk), .i_reset(i_reset),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_time(time_now), .i_time_pps(time_pps),
      .i_tx(o_tx), .i_rx(i_rx), .i_gpio_rb(gpio_rb),
      .o_loopback(loopback), .o_codec_idle(codec_idle), .o_readback(readback));

   timekeeper u_time (
      .bus_clk(bus_clk), .i_reset(i_reset),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_pps(i_pps), .o_time(time_now), .o_time_pps(time_pps));

   gpio_atr u_fe_gpio (
      .bus_clk(bus_clk), .i_reset(i_reset),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_run_rx(i_run_rx), .i_run_tx(i_run_tx), .i_gpio_in(i_fe_gpio_in),
      .o_gpio_out(o_fe_gpio_out), .o_gpio_ddr(o_fe_gpio_ddr), .o_gpio_rb(gpio_rb));

   radio_frontend u_fe (
      .bus_clk(bus_clk), .i_reset(i_reset),
      .i_run_tx(i_run_tx), .i_tx_sample(i_tx_sample), .i_codec_idle(codec_idle),
      .i_loopback(loopback), .i_rx(i_rx),
      .o_tx(o_tx), .o_rx_sample(o_rx_sample));

endmodule

// ==== src/radio_ctrl_proc.sv ====
/*
 * Control port processor
 * Puts each command on the setting bus and returns one readback word
 * per command, in command order
 */

module radio_ctrl_proc (
   input  logic                         bus_clk,
   input  logic                         i_reset,
   input  logic                         i_ctrl_stb,
   input  logic [radio_pkg::ADDR_W-1:0] i_ctrl_addr,
   input  logic [radio_pkg::DATA_W-1:0] i_ctrl_data,
   input  logic [radio_pkg::RB_W-1:0]   i_readback,
   output logic                         o_set_stb,
   output logic [radio_pkg::ADDR_W-1:0] o_set_addr,
   output logic [radio_pkg::DATA_W-1:0] o_set_data,
   output logic                         o_resp_valid,
   output logic [radio_pkg::RB_W-1:0]   o_resp_data
);

   logic rb_pend;   // Readback mux settling this cycle

   // Strobe pipeline with one stage per cycle of the command
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_set_stb    <= 1'b0;
         rb_pend      <= 1'b0;
         o_resp_valid <= 1'b0;
      end else begin
         o_set_stb    <= i_ctrl_stb;
         rb_pend      <= o_set_stb;   // Registers take the write now
         o_resp_valid <= rb_pend;
      end
   end

   // Bus payload held between commands
   always_ff @(posedge bus_clk) begin
      if (i_ctrl_stb) begin
         o_set_addr <= i_ctrl_addr;
         o_set_data <= i_ctrl_data;
      end
   end

   // Readback reflects the write just applied
   always_ff @(posedge bus_clk) begin
      if (rb_pend) begin
         o_resp_data <= i_readback;
      end
   end

   // Every bus write gets its response once the readback cycle is over
   a_resp_follows_write : assert property (
      @(posedge bus_clk) disable iff (i_reset)
      o_set_stb |=> ##1 o_resp_valid
   );

endmodule

// ==== src/radio_frontend.sv ====
/*
 * Radio front-end sample path
 * Registers the codec TX word and the RX sample, with digital loopback
 */

module radio_frontend (
   input  logic                           bus_clk,
   input  logic                           i_reset,
   input  logic                           i_run_tx,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_tx_sample,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_codec_idle,
   input  logic                           i_loopback,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
   output logic [radio_pkg::SAMPLE_W-1:0] o_tx,
   output logic [radio_pkg::SAMPLE_W-1:0] o_rx_sample
);

   ////////////////////////////////////////////////////////////////////////////
   // TX toward the codec

   // Idle word keeps the DAC at a known level when not streaming
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_tx <= '0;
      end else if (i_run_tx) begin
         o_tx <= i_tx_sample;
      end else begin
         o_tx <= i_codec_idle;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // RX from the codec

   always_ff @(posedge bus_clk) begin
      if (i_loopback) begin
         o_rx_sample <= o_tx;   // Digital loopback
      end else begin
         o_rx_sample <= i_rx;
      end
   end

endmodule

// ==== src/radio_pkg.sv ====
/*
 * Radio core shared definitions
 * Setting bus addresses, bus widths, readback slots, reset defaults
 * and the 64-bit time word
 */

package radio_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus widths

   localparam int unsigned ADDR_W   = 8;
   localparam int unsigned DATA_W   = 32;
   localparam int unsigned SAMPLE_W = 32;   // I in the upper half, Q below
   localparam int unsigned RB_W     = 64;
   localparam int unsigned GPIO_W   = 32;
   localparam int unsigned RB_SEL_W = 3;

   ////////////////////////////////////////////////////////////////////////////
   // Setting bus addresses

   localparam logic [ADDR_W-1:0] SR_LOOPBACK   = 8'd6;
   localparam logic [ADDR_W-1:0] SR_ATR        = 8'd12;   // Idle, RX, TX, FDX, then DDR
   localparam logic [ADDR_W-1:0] SR_TEST       = 8'd21;
   localparam logic [ADDR_W-1:0] SR_CODEC_IDLE = 8'd22;
   localparam logic [ADDR_W-1:0] SR_READBACK   = 8'd32;
   localparam logic [ADDR_W-1:0] SR_TIME_HI    = 8'd128;
   localparam logic [ADDR_W-1:0] SR_TIME_LO    = 8'd129;
   localparam logic [ADDR_W-1:0] SR_TIME_CTRL  = 8'd130;

   // Bits of the time control word
   localparam int unsigned TIME_CTRL_NOW = 0;
   localparam int unsigned TIME_CTRL_PPS = 1;

   // Readback slots
   localparam logic [RB_SEL_W-1:0] RB_TEST     = 3'd0;
   localparam logic [RB_SEL_W-1:0] RB_TIME     = 3'd1;
   localparam logic [RB_SEL_W-1:0] RB_TIME_PPS = 3'd2;
   localparam logic [RB_SEL_W-1:0] RB_FRONTEND = 3'd3;
   localparam logic [RB_SEL_W-1:0] RB_GPIO     = 3'd4;

   // ATR pins come out of reset as outputs
   localparam logic [GPIO_W-1:0] GPIO_DDR_DEFAULT  = '1;
   localparam logic [GPIO_W-1:0] GPIO_IDLE_DEFAULT = '0;

   // Written as two halves, counted as one word
   typedef union packed {
      logic [63:0]      count;
      logic [1:0][31:0] halves;   // [1] high, [0] low
   } time_word_u;

endpackage

// ==== src/radio_settings.sv ====
/*
 * Radio settings bank
 * Loopback, test, codec idle and readback select registers,
 * plus the readback word mux
 */

module radio_settings (
   input  logic                           bus_clk,
   input  logic                           i_reset,
   input  logic                           i_set_stb,
   input  logic [radio_pkg::ADDR_W-1:0]   i_set_addr,
   input  logic [radio_pkg::DATA_W-1:0]   i_set_data,
   input  radio_pkg::time_word_u          i_time,
   input  radio_pkg::time_word_u          i_time_pps,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_tx,
   input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
   input  logic [radio_pkg::GPIO_W-1:0]   i_gpio_rb,
   output logic                           o_loopback,
   output logic [radio_pkg::SAMPLE_W-1:0] o_codec_idle,
   output logic [radio_pkg::RB_W-1:0]     o_readback
);

   logic [radio_pkg::DATA_W-1:0]   test_q;
   logic [radio_pkg::RB_SEL_W-1:0] rb_sel;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_loopback   <= 1'b0;
         test_q       <= '0;
         o_codec_idle <= '0;
         rb_sel       <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            radio_pkg::SR_LOOPBACK:   o_loopback   <= i_set_data[0];   // TX to RX
            radio_pkg::SR_TEST:       test_q       <= i_set_data;
            radio_pkg::SR_CODEC_IDLE: o_codec_idle <= i_set_data[radio_pkg::SAMPLE_W-1:0];
            radio_pkg::SR_READBACK:   rb_sel       <= i_set_data[radio_pkg::RB_SEL_W-1:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux

   always_comb begin
      case (rb_sel)
         radio_pkg::RB_TEST:
            o_readback = {{(radio_pkg::RB_W-radio_pkg::DATA_W){1'b0}}, test_q};
         radio_pkg::RB_TIME:
            o_readback = i_time.count;
         radio_pkg::RB_TIME_PPS:
            o_readback = i_time_pps.count;
         radio_pkg::RB_FRONTEND:
            o_readback = {i_tx, i_rx};   // TX above RX
         radio_pkg::RB_GPIO:
            o_readback = {{(radio_pkg::RB_W-radio_pkg::GPIO_W){1'b0}}, i_gpio_rb};
         default:
            o_readback = '0;   // Slots 5 to 7 unused
      endcase
   end

endmodule

// ==== src/timekeeper.sv ====
/*
 * Timekeeper
 * Free-running 64-bit time, loaded now or at the next PPS edge,
 * with the time of the last PPS edge held for readback
 */

module timekeeper (
   input  logic                         bus_clk,
   input  logic                         i_reset,
   input  logic                         i_set_stb,
   input  logic [radio_pkg::ADDR_W-1:0] i_set_addr,
   input  logic [radio_pkg::DATA_W-1:0] i_set_data,
   input  logic                         i_pps,
   output radio_pkg::time_word_u        o_time,
   output radio_pkg::time_word_u        o_time_pps
);

   radio_pkg::time_word_u pending;   // Value for the next load
   logic pps_s1;
   logic pps_s2;
   logic pps_s3;
   logic pps_edge;
   logic pps_armed;   // Load waiting for PPS
   logic wr_ctrl;
   logic load_now;
   logic load_pps;

   assign pps_edge = pps_s2 & ~pps_s3;
   assign wr_ctrl  = i_set_stb && (i_set_addr == radio_pkg::SR_TIME_CTRL);
   assign load_now = wr_ctrl && i_set_data[radio_pkg::TIME_CTRL_NOW];
   assign load_pps = pps_edge && pps_armed;

   // Pending halves
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         pending.count <= '0;
      end else if (i_set_stb) begin
         if (i_set_addr == radio_pkg::SR_TIME_HI) pending.halves[1] <= i_set_data;
         if (i_set_addr == radio_pkg::SR_TIME_LO) pending.halves[0] <= i_set_data;
      end
   end

   // PPS synchronizer and rise detect
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_s3 <= 1'b0;
      end else begin
         pps_s1 <= i_pps;
         pps_s2 <= pps_s1;
         pps_s3 <= pps_s2;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Time counter

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_time.count     <= '0;
         o_time_pps.count <= '0;
         pps_armed        <= 1'b0;
      end else begin
         if (load_now || load_pps) o_time.count <= pending.count;
         else                      o_time.count <= o_time.count + 64'd1;
         if (pps_edge) o_time_pps <= o_time;   // Time seen at the edge
         if (wr_ctrl && i_set_data[radio_pkg::TIME_CTRL_PPS]) pps_armed <= 1'b1;
         else if (load_pps)                                   pps_armed <= 1'b0;
      end
   end

   a_time_counts : assert property (
      @(posedge bus_clk) disable iff (i_reset)
      !(load_now || load_pps) |=> o_time.count == $past(o_time.count) + 64'd1
   );

endmodule

// ==== tb/radio_tb_model.svh ====
/*
 * Radio core reference model for the testbench
 * Register mirror, time arithmetic and the compare tasks
 */
`ifndef RADIO_TB_MODEL_SVH
`define RADIO_TB_MODEL_SVH

logic [radio_pkg::DATA_W-1:0]   m_test;
logic [radio_pkg::DATA_W-1:0]   m_hi;   // Pending time halves
logic [radio_pkg::DATA_W-1:0]   m_lo;
logic [radio_pkg::SAMPLE_W-1:0] m_idle;
logic [radio_pkg::SAMPLE_W-1:0] m_tx;   // Front-end words seen by slot 3
logic [radio_pkg::SAMPLE_W-1:0] m_rx;
logic [radio_pkg::GPIO_W-1:0]   m_atr [4];
logic [radio_pkg::GPIO_W-1:0]   m_ddr;
logic [radio_pkg::GPIO_W-1:0]   m_gin;
logic [radio_pkg::RB_SEL_W-1:0] m_sel;
logic                           m_lb;
logic                           m_armed;
logic [63:0]                    m_base;   // Time right after edge m_base_edge
int                             m_base_edge;
logic [63:0]                    m_pps_time;

task automatic clear_model(input int start_edge);
   m_test      = '0;
   m_hi        = '0;
   m_lo        = '0;
   m_idle      = '0;
   m_tx        = '0;
   m_rx        = '0;
   m_gin       = '0;
   m_atr       = '{default: '0};
   m_ddr       = '1;
   m_sel       = '0;
   m_lb        = 1'b0;
   m_armed     = 1'b0;
   m_base      = '0;
   m_base_edge = start_edge;
   m_pps_time  = '0;
endtask

function automatic logic [63:0] time_after(input int edge_n);
   return m_base + 64'(edge_n - m_base_edge);
endfunction

// Registers take a command captured at edge cap on edge cap + 1
task automatic apply_write(input logic [radio_pkg::ADDR_W-1:0] addr,
                           input logic [radio_pkg::DATA_W-1:0] data, input int cap);
   case (addr)
      radio_pkg::SR_LOOPBACK:   m_lb     = data[0];
      radio_pkg::SR_TEST:       m_test   = data;
      radio_pkg::SR_CODEC_IDLE: m_idle   = data;
      radio_pkg::SR_READBACK:   m_sel    = data[radio_pkg::RB_SEL_W-1:0];
      radio_pkg::SR_TIME_HI:    m_hi     = data;
      radio_pkg::SR_TIME_LO:    m_lo     = data;
      radio_pkg::SR_ATR:        m_atr[0] = data;
      radio_pkg::SR_ATR + 8'd1: m_atr[1] = data;
      radio_pkg::SR_ATR + 8'd2: m_atr[2] = data;
      radio_pkg::SR_ATR + 8'd3: m_atr[3] = data;
      radio_pkg::SR_ATR + 8'd4: m_ddr    = data;
      radio_pkg::SR_TIME_CTRL: begin
         if (data[0]) begin
            m_base      = {m_hi, m_lo};
            m_base_edge = cap + 1;
         end
         if (data[1]) m_armed = 1'b1;
      end
      default: ;
   endcase
endtask

// Mux settles between the write edge and the response edge
function automatic logic [radio_pkg::RB_W-1:0] expected_readback(input int cap);
   case (m_sel)
      radio_pkg::RB_TEST:     return {32'd0, m_test};
      radio_pkg::RB_TIME:     return time_after(cap + 1);
      radio_pkg::RB_TIME_PPS: return m_pps_time;
      radio_pkg::RB_FRONTEND: return {m_tx, m_rx};
      radio_pkg::RB_GPIO:     return {32'd0, m_gin};
      default:                return '0;
   endcase
endfunction

task automatic apply_pps(input int rise);
   m_pps_time = time_after(rise + 2);   // Detector fires on the third edge
   if (m_armed) begin
      m_base      = {m_hi, m_lo};
      m_base_edge = rise + 3;
      m_armed     = 1'b0;
   end
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic rb_compare(input logic [radio_pkg::RB_W-1:0] got,
                          input logic [radio_pkg::RB_W-1:0] exp, input string what);
   n_checks++;
   if (got !== exp) begin
      n_errs++;
      $display("Mismatch at %0d ns: %s read %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic sample_compare(input logic [radio_pkg::SAMPLE_W-1:0] got,
                              input logic [radio_pkg::SAMPLE_W-1:0] exp, input string what);
   n_checks++;
   if (got !== exp) begin
      n_errs++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic gpio_compare(input logic [radio_pkg::GPIO_W-1:0] got,
                            input logic [radio_pkg::GPIO_W-1:0] exp, input string what);
   n_checks++;
   if (got !== exp) begin
      n_errs++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

`endif

// ==== tb/radio_tb.sv ====
/*
 * Radio core testbench
 * Random commands, PPS pulses and front-end traffic checked against a model
 */

module radio_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_RAND    = 16;
   localparam int N_SAMP    = 64;
   localparam int GAP_MAX   = 7;
   localparam int RESP_WAIT = 8;
   // Three cycles per command with idle gaps plus the sample loops
   localparam int CYCLE_LIMIT = 4 * N_RAND * (3 + GAP_MAX) + 3 * N_SAMP + 200;

   logic                           bus_clk;
   logic                           i_reset;
   logic                           i_ctrl_stb;
   logic [radio_pkg::ADDR_W-1:0]   i_ctrl_addr;
   logic [radio_pkg::DATA_W-1:0]   i_ctrl_data;
   logic                           o_resp_valid;
   logic [radio_pkg::RB_W-1:0]     o_resp_data;
   logic [radio_pkg::SAMPLE_W-1:0] i_rx;
   logic [radio_pkg::SAMPLE_W-1:0] i_tx_sample;
   logic                           i_run_tx;
   logic                           i_run_rx;
   logic [radio_pkg::SAMPLE_W-1:0] o_tx;
   logic [radio_pkg::SAMPLE_W-1:0] o_rx_sample;
   logic                           i_pps;
   logic [radio_pkg::GPIO_W-1:0]   i_fe_gpio_in;
   logic [radio_pkg::GPIO_W-1:0]   o_fe_gpio_out;
   logic [radio_pkg::GPIO_W-1:0]   o_fe_gpio_ddr;

   int cyc;   // Rising edges so far
   int n_checks;
   int n_errs;
   int mark_checks;
   int mark_errs;

   `include "radio_tb_model.svh"

   radio_core UUT (.*);

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("** FAIL **");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers enter and leave 1 ns after a rising edge

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge bus_clk);
         #1;
      end
   endtask

   task automatic command(input logic [radio_pkg::ADDR_W-1:0] addr,
                          input logic [radio_pkg::DATA_W-1:0] data, input string what);
      int cap;
      int waited;
      i_ctrl_stb  = 1'b1;
      i_ctrl_addr = addr;
      i_ctrl_data = data;
      idle(1);
      cap        = cyc;   // Capture edge of this command
      i_ctrl_stb = 1'b0;
      apply_write(addr, data, cap);
      waited = 0;
      while (!o_resp_valid && waited < RESP_WAIT) begin
         idle(1);
         waited++;
      end
      if (o_resp_valid) begin
         rb_compare(o_resp_data, expected_readback(cap), what);
      end else begin
         n_errs++;
         $display("Error at %0d ns: no response to the %s command", $time, what);
      end
   endtask

   task automatic pulse_pps();
      i_pps = 1'b1;
      apply_pps(cyc);
      idle(4);
      i_pps = 1'b0;
      idle(2);
   endtask

   task automatic finish_test(input string name);
      $display("Test %s: %0d checks, %0d errors", name, n_checks - mark_checks,
               n_errs - mark_errs);
      mark_checks = n_checks;
      mark_errs   = n_errs;
   endtask

   // Random streaming with o_tx and o_rx_sample checked every cycle
   task automatic sample_path(input string name);
      logic [radio_pkg::SAMPLE_W-1:0] exp_tx;
      logic [radio_pkg::SAMPLE_W-1:0] exp_rx;
      logic [radio_pkg::SAMPLE_W-1:0] prev_tx;
      i_run_tx = 1'b0;
      idle(1);
      prev_tx = m_idle;
      repeat (N_SAMP) begin
         i_run_tx    = 1'($urandom);
         i_tx_sample = $urandom;
         i_rx        = $urandom;
         exp_tx      = i_run_tx ? i_tx_sample : m_idle;
         exp_rx      = m_lb ? prev_tx : i_rx;
         idle(1);
         sample_compare(o_tx, exp_tx, "o_tx");
         sample_compare(o_rx_sample, exp_rx, "o_rx_sample");
         prev_tx = exp_tx;
      end
      m_tx = prev_tx;   // Inputs now held
      m_rx = i_rx;
      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_FRONTEND), "slot 3 TX above RX");
      finish_test(name);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [radio_pkg::DATA_W-1:0] hi;
      logic [radio_pkg::DATA_W-1:0] lo;
      void'($urandom(32'he08538a2));
      i_reset      = 1'b1;
      i_ctrl_stb   = 1'b0;
      i_ctrl_addr  = '0;
      i_ctrl_data  = '0;
      i_rx         = '0;
      i_tx_sample  = '0;
      i_run_tx     = 1'b0;
      i_run_rx     = 1'b0;
      i_pps        = 1'b0;
      i_fe_gpio_in = '0;
      idle(2);
      i_reset = 1'b0;
      clear_model(cyc);

      rb_compare({{(radio_pkg::RB_W-1){1'b0}}, o_resp_valid}, '0, "o_resp_valid after reset");
      sample_compare(o_tx, '0, "o_tx after reset");
      gpio_compare(o_fe_gpio_ddr, '1, "GPIO DDR after reset");
      gpio_compare(o_fe_gpio_out, '0, "GPIO out after reset");
      finish_test("reset");

      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST), "select slot 0");
      repeat (N_RAND) command(radio_pkg::SR_TEST, $urandom, "test register");
      repeat (N_RAND) begin
         command(radio_pkg::SR_READBACK, $urandom_range(7, 5), "select unused slot");
         command(radio_pkg::SR_TEST, $urandom, "test write on unused slot");
      end
      finish_test("scratch");

      hi = $urandom;
      lo = $urandom;
      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME), "select slot 1");
      command(radio_pkg::SR_TIME_HI, hi, "time high");
      command(radio_pkg::SR_TIME_LO, lo, "time low");
      command(radio_pkg::SR_TIME_CTRL, 32'd1, "set time now");
      repeat (N_RAND) begin
         idle($urandom_range(GAP_MAX));
         command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME), "time read");
      end
      finish_test("time set");

      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME_PPS), "select slot 2");
      pulse_pps();
      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME_PPS), "last PPS time");
      command(radio_pkg::SR_TIME_HI, $urandom, "PPS time high");
      command(radio_pkg::SR_TIME_LO, $urandom, "PPS time low");
      command(radio_pkg::SR_TIME_CTRL, 32'd2, "arm set at PPS");
      pulse_pps();
      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME_PPS), "last PPS before load");
      repeat (4) begin
         idle($urandom_range(GAP_MAX));
         command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME), "time after PPS load");
      end
      finish_test("pps");

      command(radio_pkg::SR_CODEC_IDLE, $urandom, "codec idle");
      command(radio_pkg::SR_LOOPBACK, 32'd0, "loopback off");
      sample_path("tx and rx");
      command(radio_pkg::SR_LOOPBACK, 32'd1, "loopback on");
      sample_path("loopback");

      i_fe_gpio_in = $urandom;
      m_gin        = i_fe_gpio_in;
      command(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_GPIO), "GPIO input");
      for (int s = 0; s < 5; s++) begin
         command(radio_pkg::SR_ATR + 8'(s), $urandom, "ATR register");
      end
      repeat (N_SAMP) begin
         i_run_tx = 1'($urandom);
         i_run_rx = 1'($urandom);
         idle(1);
         gpio_compare(o_fe_gpio_out, m_atr[{i_run_tx, i_run_rx}], "ATR output");
         gpio_compare(o_fe_gpio_ddr, m_ddr, "GPIO DDR");
      end
      finish_test("gpio atr");

      $display("Summary: %0d checks, %0d errors, %0d cycles", n_checks, n_errs, cyc);
      if (n_errs == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
